//--- tb.f
+incdir+.
stream_flit_pkg.sv
stream_ctrl_pkg.sv
stream_fifo.sv
stream_addressgen.sv
stream_strbgen.sv
stream_store_unit.sv
stream_store_top.sv
tb_store_checker.sv
tb_stream_store.sv

//--- tb_stream_store.sv
`timescale 1ns/1ps
/* runs a fixed table of transfers through the store path. valid gaps, data
   and gnt stalls come from xorshift, so every run is the same. */
module tb_stream_store
  import stream_ctrl_pkg::*, stream_flit_pkg::*;
();

  localparam int          N_TESTS = 5;
  localparam logic [31:0] SEED    = 32'hf37a7a60;

  logic         clk_i;
  logic         rst_ni;
  logic         start;
  stream_cfg_t  cfg;
  logic         in_valid;
  logic         in_ready;
  stream_flit_t in_flit;
  logic         mem_req;
  logic         mem_gnt;
  mem_req_t     mem_wr;
  logic         done;
  int           chk_errors;
  int           chk_grants;
  int           chk_dones;
  logic [31:0]  data_state;  // data, strobes and gaps.
  logic [31:0]  gnt_state;   // grant pattern.
  int           stall_level; // higher means fewer grants.
  int           test_fails;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // field order is base_addr, line_length, line_stride, n_lines, remainder.
  task automatic test_setup(input int idx, output stream_cfg_t c, output int stall);
    case (idx)
      0:       c = {32'h0000_1000, 16'd4, 16'h0040, 16'd3, 8'd0};
      1:       c = {32'h2000_0010, 16'd5, 16'h0100, 16'd4, 8'd3};
      2:       c = {32'h8000_0000, 16'd1, 16'h0008, 16'd6, 8'd1};  // every word masked.
      3:       c = {32'h0000_3ffc, 16'd7, 16'h0020, 16'd5, 8'd2};
      default: c = {32'h1234_5670, 16'd3, 16'hfff0, 16'd8, 8'd4};  // remainder of a full word.
    endcase
    stall = idx; // stalls grow test by test.
  endtask

  task automatic send_word();
    stream_flit_t f;
    logic         taken;
    data_state = xorshift(data_state);
    while (data_state[1:0] == 2'b00) begin // random idle cycles.
      in_valid <= 1'b0;
      @(posedge clk_i);
      data_state = xorshift(data_state);
    end
    data_state = xorshift(data_state);
    f.data     = data_state;
    data_state = xorshift(data_state);
    f.strb     = data_state[STRB_WIDTH-1:0];
    in_valid <= 1'b1;
    in_flit  <= f;
    // valid stays up until ready is seen at mid cycle.
    do begin
      @(negedge clk_i);
      taken = in_ready;
      @(posedge clk_i);
    end while (!taken);
  endtask

  task automatic wait_done();
    logic seen;
    do begin
      @(negedge clk_i);
      seen = done;
      @(posedge clk_i);
    end while (!seen);
  endtask

  stream_store_top dut (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (start),
    .cfg_i      (cfg),
    .in_valid_i (in_valid),
    .in_ready_o (in_ready),
    .in_flit_i  (in_flit),
    .mem_req_o  (mem_req),
    .mem_gnt_i  (mem_gnt),
    .mem_o      (mem_wr),
    .done_o     (done)
  );

  tb_store_checker i_checker (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (start),
    .cfg_i      (cfg),
    .in_valid_i (in_valid),
    .in_ready_i (in_ready),
    .in_flit_i  (in_flit),
    .mem_req_i  (mem_req),
    .mem_gnt_i  (mem_gnt),
    .mem_i      (mem_wr),
    .done_i     (done),
    .errors_o   (chk_errors),
    .grants_o   (chk_grants),
    .dones_o    (chk_dones)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i; // 20 ns period.
  end

  // grant model with random stalls at the current level.
  initial begin
    gnt_state = {SEED[15:0], SEED[31:16]};
    mem_gnt   = 1'b0;
    forever begin
      @(posedge clk_i);
      gnt_state = xorshift(gnt_state);
      mem_gnt <= (int'(gnt_state[2:0]) >= stall_level);
    end
  end

  // watchdog allows 40 cycles per word of all tests plus slack.
  initial begin
    stream_cfg_t c;
    int          stall;
    int          total;
    total = 0;
    for (int t = 0; t < N_TESTS; t++) begin
      test_setup(t, c, stall);
      total += c.line_length * c.n_lines;
    end
    repeat (total * 40 + 1000) @(posedge clk_i);
    $display("timeout: the run did not finish within %0d cycles", total * 40 + 1000);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    stream_cfg_t c;
    int          stall;
    int          words;
    int          err0;
    int          gnt0;
    int          done0;
    logic        bad;
    data_state  = SEED;
    rst_ni      = 1'b0;
    start       = 1'b0;
    cfg         = '0;
    in_valid    = 1'b0;
    in_flit     = '0;
    stall_level = 0;
    test_fails  = 0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (5) @(posedge clk_i); // req and done must stay low while idle.
    for (int t = 0; t < N_TESTS; t++) begin
      test_setup(t, c, stall);
      words = c.line_length * c.n_lines;
      @(negedge clk_i); // counters are settled mid cycle.
      err0  = chk_errors;
      gnt0  = chk_grants;
      done0 = chk_dones;
      @(posedge clk_i);
      cfg         <= c; // stable one cycle ahead of start.
      stall_level <= stall;
      @(posedge clk_i);
      start <= 1'b1;
      @(posedge clk_i);
      start <= 1'b0;
      for (int w = 0; w < words; w++) begin
        send_word();
      end
      in_valid <= 1'b0;
      wait_done();
      repeat (4) @(posedge clk_i); // stray requests would show in this quiet time.
      @(negedge clk_i);
      bad = (chk_errors != err0) || (chk_grants - gnt0 != words) || (chk_dones - done0 != 1);
      if (chk_grants - gnt0 != words) begin
        $display("[FAIL] mem_gnt_i grants: got 0x%0h expected 0x%0h", chk_grants - gnt0, words);
      end
      if (chk_dones - done0 != 1) begin
        $display("[FAIL] done_o pulses: got 0x%0h expected 0x1", chk_dones - done0);
      end
      if (bad) begin
        test_fails++;
      end
      $display("test %0d %s: %0d words, line_length %0d, remainder %0d, stall %0d",
               t, bad ? "failed" : "ok", words, c.line_length, c.line_length_remainder, stall);
    end
    $display("%0d tests, %0d failed, %0d writes checked, %0d checker errors",
             N_TESTS, test_fails, chk_grants, chk_errors);
    if (test_fails == 0 && chk_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- tb_store_checker.sv
`timescale 1ns/1ps
/* checks every granted write against a model built from the cfg latched at
   start and the accepted input words, in order. counters are cumulative.
   idle checks on the memory side begin once reset is released. */
module tb_store_checker
  import stream_ctrl_pkg::*, stream_flit_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         start_i,
  input  stream_cfg_t  cfg_i,
  input  logic         in_valid_i,
  input  logic         in_ready_i,
  input  stream_flit_t in_flit_i,
  input  logic         mem_req_i,
  input  logic         mem_gnt_i,
  input  mem_req_t     mem_i,
  input  logic         done_i,
  output int           errors_o,
  output int           grants_o,
  output int           dones_o
);

  stream_cfg_t  cfg_q;       // cfg of the running transfer.
  stream_flit_t words_q[$];  // accepted words not yet written.
  int unsigned  idx_q;       // index of the next write in the transfer.
  int unsigned  total_q;
  bit           active_q;    // between start and done.

  // expected write for word idx of a transfer from the cfg rules alone.
  function automatic mem_req_t expected_write(input stream_cfg_t cfg, input int unsigned idx,
                                              input stream_flit_t flit);
    mem_req_t              exp;
    int unsigned           line_idx;
    int unsigned           word_idx;
    logic [STRB_WIDTH-1:0] keep;
    line_idx = idx / cfg.line_length;
    word_idx = idx % cfg.line_length;
    keep     = '1; // full word unless the line ends short.
    if (word_idx == cfg.line_length - 1 && cfg.line_length_remainder != 0 &&
        cfg.line_length_remainder < STRB_WIDTH) begin
      keep = (1 << cfg.line_length_remainder) - 1; // low r bytes.
    end
    exp.addr  = cfg.base_addr + line_idx * cfg.line_stride + word_idx * 4;
    exp.wdata = flit.data;
    exp.be    = flit.strb & keep;
    return exp;
  endfunction

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp) begin
      errors_o++;
      $display("[FAIL] %s: got 0x%0h expected 0x%0h (word %0d)", name, got, exp, idx_q);
    end
  endtask

  task automatic complain(input string what);
    errors_o++;
    $display("error at %0t: %s", $time, what);
  endtask

  always @(posedge clk_i) begin
    stream_flit_t f;
    mem_req_t     exp;
    // nothing may move on the memory side outside a transfer after reset.
    if (rst_ni === 1'b1 && !active_q && (mem_req_i !== 1'b0 || done_i !== 1'b0)) begin
      complain("memory request or done seen outside a transfer");
    end
    if (start_i && !active_q) begin
      active_q = 1'b1;
      cfg_q    = cfg_i;
      idx_q    = 0;
      total_q  = cfg_i.line_length * cfg_i.n_lines;
      words_q.delete();
    end
    if (in_valid_i && in_ready_i) begin
      if (!active_q) begin
        complain("input word accepted outside a transfer");
      end
      words_q.push_back(in_flit_i);
    end
    if (done_i === 1'b1) begin
      dones_o++;
      if (!(mem_req_i && mem_gnt_i)) begin
        complain("done pulsed without a granted write");
      end
    end
    if (active_q && mem_req_i && mem_gnt_i) begin
      grants_o++;
      if (words_q.size() == 0) begin
        complain("memory write with no accepted input word behind it");
      end else begin
        f   = words_q.pop_front();
        exp = expected_write(cfg_q, idx_q, f);
        compare_value("mem_o.addr", mem_i.addr, exp.addr);
        compare_value("mem_o.wdata", mem_i.wdata, exp.wdata);
        compare_value("mem_o.be", mem_i.be, exp.be);
      end
      compare_value("done_o", done_i, idx_q == total_q - 1);
      if (idx_q == total_q - 1) begin
        active_q = 1'b0; // transfer closed by its final grant.
        if (words_q.size() != 0) begin
          complain("input words left over after the final write");
        end
      end
      idx_q++;
    end
  end

endmodule

//--- stream_store_top.sv
`timescale 1ns/1ps
/* cfg_i must stay stable from start until done. latency varies with
   gnt and input gaps; done marks the end of each transfer. */
module stream_store_top
  import stream_ctrl_pkg::*, stream_flit_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         start_i,
  input  stream_cfg_t  cfg_i,
  input  logic         in_valid_i,
  output logic         in_ready_o,
  input  stream_flit_t in_flit_i,
  output logic         mem_req_o,
  input  logic         mem_gnt_i,
  output mem_req_t     mem_o,
  output logic         done_o
);

  addr_entry_t  addr_entry;  // generator to address queue.
  addr_entry_t  addr_head;
  logic         addr_push;
  logic         addr_full;
  logic         addr_empty;
  stream_flit_t strb_flit;   // strobe generator to data queue.
  stream_flit_t data_head;
  logic         strb_valid;
  logic         data_ready;
  logic         data_push;
  logic         data_full;
  logic         data_empty;
  logic         pop;         // both queues at once.

  assign data_ready = ~data_full;              // stream ready is "not full".
  assign data_push  = strb_valid & data_ready; // push only on a real transfer.

  stream_addressgen i_addressgen (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (start_i),
    .cfg_i   (cfg_i),
    .full_i  (addr_full),
    .push_o  (addr_push),
    .entry_o (addr_entry),
    .busy_o  ()           // status only.
  );

  stream_strbgen i_strbgen (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (start_i),
    .cfg_i       (cfg_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_flit_i   (in_flit_i),
    .out_valid_o (strb_valid),
    .out_ready_i (data_ready),
    .out_flit_o  (strb_flit)
  );

  stream_fifo #(.payload_t(addr_entry_t)) i_addr_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (addr_push),
    .data_i  (addr_entry),
    .full_o  (addr_full),
    .pop_i   (pop),
    .data_o  (addr_head),
    .empty_o (addr_empty)
  );

  stream_fifo #(.payload_t(stream_flit_t)) i_data_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (data_push),
    .data_i  (strb_flit),
    .full_o  (data_full),
    .pop_i   (pop),
    .data_o  (data_head),
    .empty_o (data_empty)
  );

  stream_store_unit i_store_unit (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .addr_empty_i (addr_empty),
    .addr_i       (addr_head),
    .data_empty_i (data_empty),
    .data_i       (data_head),
    .pop_o        (pop),
    .mem_req_o    (mem_req_o),
    .mem_gnt_i    (mem_gnt_i),
    .mem_o        (mem_o),
    .done_o       (done_o)
  );

endmodule

//--- stream_store_unit.sv
`timescale 1ns/1ps
/* one write in flight. req and payload hold until gnt; both queues pop
   on the granted cycle, so the next req comes two cycles later at best. */
module stream_store_unit
  import stream_ctrl_pkg::*, stream_flit_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         addr_empty_i,
  input  addr_entry_t  addr_i,
  input  logic         data_empty_i,
  input  stream_flit_t data_i,
  output logic         pop_o,
  output logic         mem_req_o,
  input  logic         mem_gnt_i,
  output mem_req_t     mem_o,
  output logic         done_o
);

  logic     req_q;   // request pending.
  logic     last_q;  // pending word closes the transfer.
  mem_req_t mem_q;   // held request payload.
  logic     load;
  logic     grant;

  // take the two heads only when both are there and nothing is pending.
  assign load  = ~req_q & ~addr_empty_i & ~data_empty_i;
  assign grant = req_q & mem_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q  <= 1'b0;
      last_q <= 1'b0;
    end else if (load) begin
      req_q  <= 1'b1;
      last_q <= addr_i.last;
    end else if (grant) begin
      req_q  <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      mem_q.addr  <= addr_i.addr;
      mem_q.wdata <= data_i.data;
      mem_q.be    <= data_i.strb; // already masked upstream.
    end
  end

  assign pop_o     = grant; // heads leave together with the grant.
  assign mem_req_o = req_q;
  assign mem_o     = mem_q;
  assign done_o    = grant & last_q; // one cycle, on the final grant.

endmodule

//--- stream_strbgen.sv
`timescale 1ns/1ps
/* zero latency on the data path; only the strobe is rewritten.
   a remainder of STRB_WIDTH or more leaves the strobe unmasked. */
module stream_strbgen
  import stream_ctrl_pkg::*, stream_flit_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         start_i,
  input  stream_cfg_t  cfg_i,
  input  logic         in_valid_i,
  output logic         in_ready_o,
  input  stream_flit_t in_flit_i,
  output logic         out_valid_o,
  input  logic         out_ready_i,
  output stream_flit_t out_flit_o
);

  logic [15:0]           word_cnt_q;  // accepted words in the current line.
  logic [STRB_WIDTH-1:0] rem_mask;    // low bytes kept on the last word.
  logic                  line_last;
  logic                  xfer;

  assign xfer      = in_valid_i & out_ready_i;
  assign line_last = (word_cnt_q == cfg_i.line_length - 16'd1);

  // counts modulo line_length, only on a real transfer.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_cnt_q <= '0;
    end else if (start_i) begin
      word_cnt_q <= '0; // new transfer starts at word 0.
    end else if (xfer) begin
      if (word_cnt_q < cfg_i.line_length - 16'd1) begin
        word_cnt_q <= word_cnt_q + 16'd1;
      end else begin
        word_cnt_q <= '0;
      end
    end
  end

  // thermometer decode of the remainder.
  always_comb begin
    rem_mask = '0;
    for (int i = 0; i < STRB_WIDTH; i++) begin
      if (i < int'(cfg_i.line_length_remainder)) begin
        rem_mask[i] = 1'b1;
      end
    end
  end

  assign out_valid_o     = in_valid_i;  // handshake passes straight through.
  assign in_ready_o      = out_ready_i;
  assign out_flit_o.data = in_flit_i.data;
  assign out_flit_o.strb = (line_last && (cfg_i.line_length_remainder != '0)) ?
                           (in_flit_i.strb & rem_mask) : in_flit_i.strb;

endmodule

//--- stream_addressgen.sv
`timescale 1ns/1ps
/* cfg_i is sampled on start only; a start while busy is dropped.
   line_length and n_lines must be nonzero, else the start is dropped too. */
module stream_addressgen
  import stream_ctrl_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        start_i,
  input  stream_cfg_t cfg_i,
  input  logic        full_i,
  output logic        push_o,
  output addr_entry_t entry_o,
  output logic        busy_o
);

  stream_cfg_t           cfg_q;        // latched transfer description.
  logic                  busy_q;
  logic [15:0]           word_cnt_q;   // word index within the line.
  logic [15:0]           line_cnt_q;   // line index within the transfer.
  logic [ADDR_WIDTH-1:0] line_base_q;  // address of word 0 of this line.
  logic                  cfg_ok;
  logic                  launch;
  logic                  word_end;
  logic                  xfer_end;

  // empty transfers never start.
  assign cfg_ok = (cfg_i.line_length != '0) && (cfg_i.n_lines != '0);
  assign launch = start_i && !busy_q && cfg_ok;

  assign word_end = (word_cnt_q == cfg_q.line_length - 16'd1); // last word of a line.
  assign xfer_end = word_end && (line_cnt_q == cfg_q.n_lines - 16'd1);

  // one entry per cycle while the queue has room.
  assign push_o       = busy_q & ~full_i;
  assign entry_o.addr = line_base_q + (ADDR_WIDTH'(word_cnt_q) << 2); // 4 bytes per word.
  assign entry_o.last = xfer_end;
  assign busy_o       = busy_q;

  always_ff @(posedge clk_i) begin
    if (launch) begin
      cfg_q <= cfg_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      word_cnt_q  <= '0;
      line_cnt_q  <= '0;
      line_base_q <= '0;
    end else if (launch) begin
      busy_q      <= 1'b1;
      word_cnt_q  <= '0;
      line_cnt_q  <= '0;
      line_base_q <= cfg_i.base_addr; // first line starts at base.
    end else if (push_o) begin
      if (xfer_end) begin
        busy_q <= 1'b0; // idle from the next cycle.
      end
      if (word_end) begin
        // next line, base moves by the stride.
        word_cnt_q  <= '0;
        line_cnt_q  <= line_cnt_q + 16'd1;
        line_base_q <= line_base_q + ADDR_WIDTH'(cfg_q.line_stride);
      end else begin
        word_cnt_q <= word_cnt_q + 16'd1;
      end
    end
  end

endmodule

//--- stream_fifo.sv
`timescale 1ns/1ps
/* registered circular buffer. push while full is taken only with a pop;
   data_o is the head and holds no meaning while empty_o is high. */
`include "stream_settings.svh"

module stream_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = `STREAM_FIFO_DEPTH
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  payload_t data_i,
  output logic     full_o,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];  // storage.
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;        // occupancy.
  logic             do_push;
  logic             do_pop;

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);

  assign do_pop  = pop_i & ~empty_o;
  assign do_push = push_i & (~full_o | do_pop); // full slot frees on the same edge.

  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        // wrap explicitly, depth need not be a power of two.
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop); // both, no change.
    end
  end

endmodule

//--- stream_ctrl_pkg.sv
/* control side types. cfg fields are held stable for a whole transfer;
   line_length and n_lines count from 1. */
package stream_ctrl_pkg;

`include "stream_settings.svh"

  localparam int unsigned ADDR_WIDTH = `STREAM_ADDR_WIDTH;

  // transfer description.
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] base_addr;
    logic [15:0]           line_length;            // words per line.
    logic [15:0]           line_stride;            // bytes between line starts.
    logic [15:0]           n_lines;
    logic [7:0]            line_length_remainder;  // valid bytes of last word, 0 = all.
  } stream_cfg_t;

  // address queue entry, one per word.
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic                  last;  // final word of the transfer.
  } addr_entry_t;

endpackage

//--- stream_flit_pkg.sv
/* stream and memory side types. strobe carries one bit per data byte,
   bit 0 is the lowest byte of the word. */
package stream_flit_pkg;

`include "stream_settings.svh"

  localparam int unsigned DATA_WIDTH = `STREAM_DATA_WIDTH;
  localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8; // one per byte.

  // one word of the input stream.
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
  } stream_flit_t;

  // one write on the req/gnt memory port.
  typedef struct packed {
    logic [`STREAM_ADDR_WIDTH-1:0] addr;  // byte address, word aligned.
    logic [DATA_WIDTH-1:0]         wdata;
    logic [STRB_WIDTH-1:0]         be;    // byte enables.
  } mem_req_t;

endpackage

//--- stream_settings.svh
/* widths and queue depth shared by both packages and the FIFO.
   data width must be a multiple of 8; FIFO depth 2 or more. */
`ifndef STREAM_SETTINGS_SVH
`define STREAM_SETTINGS_SVH

// data word of the stream, in bits.
`define STREAM_DATA_WIDTH 32

// byte address on the memory port.
`define STREAM_ADDR_WIDTH 32

// entries per queue, address and data alike.
`define STREAM_FIFO_DEPTH 4

`endif
